//--- rtl/sbus_pkg.sv
/* Shared widths, latency, types and controller states for the serial bus node.
   Every RTL file and the testbench refer to these by scoped name. */
`default_nettype none

package sbus_pkg;

    localparam int ADDR_WIDTH   = 8;
    localparam int DATA_WIDTH   = 8;
    localparam int ID_WIDTH     = 3;
    localparam int MEM_LATENCY  = 3;
    localparam int SHIFT_WIDTH  = (ADDR_WIDTH > DATA_WIDTH) ? ADDR_WIDTH : DATA_WIDTH;
    localparam int CNT_WIDTH    = $clog2(SHIFT_WIDTH + 1);
    localparam int ID_CNT_WIDTH = $clog2(ID_WIDTH);

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [ID_WIDTH-1:0]    node_id_t;
    typedef logic [SHIFT_WIDTH-1:0] shift_t;
    typedef logic [CNT_WIDTH-1:0]   bit_cnt_t;

    typedef enum logic [3:0] {
        IDLE,
        START2,
        MATCH_ID,
        WAIT_PEER,
        ADDR_RX,
        ADDR_ACK,
        DATA_WAIT_MARK,
        DATA_RX,
        FREEZE,
        MEM_WRITE,
        MEM_READ,
        WAIT_GRANT_WR,
        WRITE_ACK,
        WAIT_GRANT_RD,
        TX_DATA
    } slave_state_t;

endpackage

`default_nettype wire

//--- rtl/sbus_link_if.sv
/* Link between the slave controller and the serial/parallel bit shifter.
   Carries receive enable and length, received words and the transmit sequence. */
`timescale 1ns/1ps
`default_nettype none

interface sbus_link_if;

    logic               rx_en;
    sbus_pkg::bit_cnt_t width;
    logic               tx_start;
    sbus_pkg::shift_t   tx_word;
    sbus_pkg::shift_t   rx_word;
    logic               rx_dv;
    logic               tx_bit;
    logic               tx_active;
    logic               tx_done;

    modport ctrl (
        output rx_en, width, tx_start, tx_word,
        input  rx_word, rx_dv, tx_bit, tx_active, tx_done
    );

    modport shifter (
        input  rx_en, width, tx_start, tx_word,
        output rx_word, rx_dv, tx_bit, tx_active, tx_done
    );

endinterface

`default_nettype wire

//--- rtl/sbus_mem_if.sv
/* Request and response signals between the slave controller and the local memory. */
`timescale 1ns/1ps
`default_nettype none

interface sbus_mem_if;

    logic            wr_en;
    logic            rd_req;
    sbus_pkg::addr_t addr;
    sbus_pkg::data_t wdata;
    sbus_pkg::data_t rdata;
    logic            done;

    modport ctrl (
        output wr_en, rd_req, addr, wdata,
        input  rdata, done
    );

    modport mem (
        input  wr_en, rd_req, addr, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

//--- rtl/bit_shifter.sv
/* Two-way serial/parallel shifter. Collects width bits MSB first while rx_en is high,
   and sends a start bit plus one data word MSB first after tx_start. */
`timescale 1ns/1ps
`default_nettype none

module bit_shifter (
    input  logic          clk,
    input  logic          rstn,
    input  logic          sda_in,
    sbus_link_if.shifter  link
);

    sbus_pkg::shift_t   shreg;
    sbus_pkg::bit_cnt_t cnt;
    logic               tx_active;
    logic               tx_lead;
    logic               rx_dv;
    logic               tx_done;

    // counter and transmit sequencer, transmit has priority
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt       <= '0;
            tx_active <= 1'b0;
            tx_lead   <= 1'b0;
            rx_dv     <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            rx_dv   <= 1'b0;
            tx_done <= 1'b0;
            if (link.tx_start) begin
                cnt       <= '0;
                tx_active <= 1'b1;
                tx_lead   <= 1'b1;
            end else if (tx_active) begin
                if (tx_lead) begin
                    tx_lead <= 1'b0;
                end else if (cnt == sbus_pkg::bit_cnt_t'(sbus_pkg::DATA_WIDTH - 1)) begin
                    cnt       <= '0;
                    tx_active <= 1'b0;
                    tx_done   <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (link.rx_en) begin
                if (cnt == link.width - 1'b1) begin
                    cnt   <= '0;
                    rx_dv <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else begin
                cnt <= '0;
            end
        end
    end

    // one register serves both directions
    always_ff @(posedge clk) begin
        if (link.tx_start) begin
            shreg <= link.tx_word;
        end else if (tx_active && !tx_lead) begin
            shreg <= {shreg[sbus_pkg::SHIFT_WIDTH-2:0], 1'b1};
        end else if (link.rx_en && !tx_active) begin
            shreg <= {shreg[sbus_pkg::SHIFT_WIDTH-2:0], sda_in};
        end
    end

    assign link.rx_word   = shreg;
    assign link.rx_dv     = rx_dv;
    // start bit first, then the word from its top bit
    assign link.tx_bit    = tx_lead ? 1'b0 : shreg[sbus_pkg::DATA_WIDTH-1];
    assign link.tx_active = tx_active;
    assign link.tx_done   = tx_done;

endmodule

`default_nettype wire

//--- rtl/slave_ctrl.sv
/* Bus protocol FSM of the node: start and id match, address and data reception,
   acks, freeze hold, memory request and read-back over the serial line. */
`timescale 1ns/1ps
`default_nettype none

module slave_ctrl #(
    parameter sbus_pkg::node_id_t node_id = 3'd5
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       sda_in,
    input  logic       rd_wrt,
    input  logic       bus_util,
    input  logic       arbiter_cmd,
    input  logic       freeze_sw,
    output logic       sda_oe,
    output logic       sda_out,
    output logic       busy,
    sbus_link_if.ctrl  link,
    sbus_mem_if.ctrl   mem
);

    sbus_pkg::slave_state_t            state;
    logic [sbus_pkg::ID_CNT_WIDTH-1:0] id_cnt;
    logic [sbus_pkg::ID_WIDTH-2:0]     id_sr;
    sbus_pkg::node_id_t                id_next;
    logic                              phase;
    logic                              is_wr;
    logic                              wr_en_q;
    logic                              rd_req_q;
    sbus_pkg::addr_t                   addr_q;
    sbus_pkg::data_t                   wdata_q;
    sbus_pkg::data_t                   rdata_q;

    assign id_next = {id_sr, sda_in};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= sbus_pkg::IDLE;
            id_cnt   <= '0;
            id_sr    <= '0;
            phase    <= 1'b0;
            is_wr    <= 1'b0;
            wr_en_q  <= 1'b0;
            rd_req_q <= 1'b0;
        end else begin
            wr_en_q  <= 1'b0;
            rd_req_q <= 1'b0;
            case (state)
                sbus_pkg::IDLE: begin
                    if (!sda_in) begin
                        state <= sbus_pkg::START2;
                    end
                end
                sbus_pkg::START2: begin
                    id_cnt <= '0;
                    state  <= sda_in ? sbus_pkg::WAIT_PEER : sbus_pkg::MATCH_ID;
                end
                sbus_pkg::MATCH_ID: begin
                    id_sr  <= id_next[sbus_pkg::ID_WIDTH-2:0];
                    id_cnt <= id_cnt + 1'b1;
                    if (int'(id_cnt) == sbus_pkg::ID_WIDTH - 1) begin
                        state <= (id_next == node_id) ? sbus_pkg::ADDR_RX
                                                      : sbus_pkg::WAIT_PEER;
                    end
                end
                // another node owns this frame
                sbus_pkg::WAIT_PEER: begin
                    if (bus_util) begin
                        state <= sbus_pkg::IDLE;
                    end
                end
                sbus_pkg::ADDR_RX: begin
                    phase <= 1'b0;
                    if (link.rx_dv) begin
                        state <= sbus_pkg::ADDR_ACK;
                    end
                end
                sbus_pkg::ADDR_ACK: begin
                    phase <= ~phase;
                    if (phase) begin
                        // direction is taken in the second ack cycle
                        is_wr <= rd_wrt;
                        state <= rd_wrt ? sbus_pkg::DATA_WAIT_MARK : sbus_pkg::FREEZE;
                    end
                end
                // low then one high marker bit before the data
                sbus_pkg::DATA_WAIT_MARK: begin
                    if (!sda_in) begin
                        phase <= 1'b1;
                    end else if (phase) begin
                        phase <= 1'b0;
                        state <= sbus_pkg::DATA_RX;
                    end
                end
                sbus_pkg::DATA_RX: begin
                    if (link.rx_dv) begin
                        state <= sbus_pkg::FREEZE;
                    end
                end
                sbus_pkg::FREEZE: begin
                    if (!freeze_sw) begin
                        wr_en_q  <= is_wr;
                        rd_req_q <= !is_wr;
                        state    <= is_wr ? sbus_pkg::MEM_WRITE : sbus_pkg::MEM_READ;
                    end
                end
                sbus_pkg::MEM_WRITE: begin
                    if (mem.done) begin
                        state <= sbus_pkg::WAIT_GRANT_WR;
                    end
                end
                sbus_pkg::MEM_READ: begin
                    if (mem.done) begin
                        state <= sbus_pkg::WAIT_GRANT_RD;
                    end
                end
                sbus_pkg::WAIT_GRANT_WR: begin
                    phase <= 1'b0;
                    if (arbiter_cmd) begin
                        state <= sbus_pkg::WRITE_ACK;
                    end
                end
                sbus_pkg::WRITE_ACK: begin
                    phase <= ~phase;
                    if (phase) begin
                        state <= sbus_pkg::IDLE;
                    end
                end
                sbus_pkg::WAIT_GRANT_RD: begin
                    if (arbiter_cmd) begin
                        state <= sbus_pkg::TX_DATA;
                    end
                end
                sbus_pkg::TX_DATA: begin
                    if (link.tx_done) begin
                        state <= sbus_pkg::IDLE;
                    end
                end
                default: begin
                    state <= sbus_pkg::IDLE;
                end
            endcase
        end
    end

    // address, write data and read data
    always_ff @(posedge clk) begin
        if (state == sbus_pkg::ADDR_RX && link.rx_dv) begin
            addr_q <= link.rx_word[sbus_pkg::ADDR_WIDTH-1:0];
        end
        if (state == sbus_pkg::DATA_RX && link.rx_dv) begin
            wdata_q <= link.rx_word[sbus_pkg::DATA_WIDTH-1:0];
        end
        if (state == sbus_pkg::MEM_READ && mem.done) begin
            rdata_q <= mem.rdata;
        end
    end

    // receive stops in the dv cycle so no extra bit is taken
    assign link.rx_en = (state == sbus_pkg::ADDR_RX || state == sbus_pkg::DATA_RX)
                        && !link.rx_dv;
    assign link.width = (state == sbus_pkg::DATA_RX)
                        ? sbus_pkg::bit_cnt_t'(sbus_pkg::DATA_WIDTH)
                        : sbus_pkg::bit_cnt_t'(sbus_pkg::ADDR_WIDTH);
    assign link.tx_start = (state == sbus_pkg::WAIT_GRANT_RD) && arbiter_cmd;
    assign link.tx_word  = sbus_pkg::shift_t'(rdata_q);

    assign mem.wr_en  = wr_en_q;
    assign mem.rd_req = rd_req_q;
    assign mem.addr   = addr_q;
    assign mem.wdata  = wdata_q;

    assign busy = (state == sbus_pkg::FREEZE || state == sbus_pkg::MEM_WRITE
                   || state == sbus_pkg::MEM_READ) && !mem.done;

    // line driver, idles high when released
    always_comb begin
        sda_oe  = 1'b0;
        sda_out = 1'b1;
        case (state)
            sbus_pkg::ADDR_ACK: begin
                sda_oe  = 1'b1;
                sda_out = 1'b0;
            end
            sbus_pkg::WRITE_ACK: begin
                sda_oe  = 1'b1;
                sda_out = phase;
            end
            sbus_pkg::TX_DATA: begin
                sda_oe  = link.tx_active;
                sda_out = link.tx_bit;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/local_mem.sv
/* Node word memory behind a fixed-latency request pipeline.
   done pulses MEM_LATENCY cycles after wr_en or rd_req, with rdata valid alongside. */
`timescale 1ns/1ps
`default_nettype none

module local_mem (
    input  logic     clk,
    input  logic     rstn,
    sbus_mem_if.mem  mem
);

    logic [sbus_pkg::MEM_LATENCY-1:0] vld;
    logic [sbus_pkg::MEM_LATENCY-2:0] wr_p;
    sbus_pkg::addr_t                  addr_p [sbus_pkg::MEM_LATENCY-1];
    sbus_pkg::data_t                  data_p [sbus_pkg::MEM_LATENCY-1];
    sbus_pkg::data_t                  mem_q  [2**sbus_pkg::ADDR_WIDTH];
    sbus_pkg::data_t                  rdata_q;

    // valid bits walk one stage per cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld <= '0;
        end else begin
            vld <= {vld[sbus_pkg::MEM_LATENCY-2:0], mem.wr_en | mem.rd_req};
        end
    end

    always_ff @(posedge clk) begin
        wr_p[0]   <= mem.wr_en;
        addr_p[0] <= mem.addr;
        data_p[0] <= mem.wdata;
        for (int i = 1; i < sbus_pkg::MEM_LATENCY - 1; i++) begin
            wr_p[i]   <= wr_p[i-1];
            addr_p[i] <= addr_p[i-1];
            data_p[i] <= data_p[i-1];
        end
        // array access on entry to the last stage
        if (vld[sbus_pkg::MEM_LATENCY-2]) begin
            if (wr_p[sbus_pkg::MEM_LATENCY-2]) begin
                mem_q[addr_p[sbus_pkg::MEM_LATENCY-2]] <= data_p[sbus_pkg::MEM_LATENCY-2];
            end
            rdata_q <= mem_q[addr_p[sbus_pkg::MEM_LATENCY-2]];
        end
    end

    assign mem.done  = vld[sbus_pkg::MEM_LATENCY-1];
    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

//--- rtl/sbus_node.sv
/* Serial bus node top level. Wires the bit shifter, the slave controller and
   the local memory together; the bus line is split into sda_in, sda_oe and sda_out. */
`timescale 1ns/1ps
`default_nettype none

module sbus_node #(
    parameter sbus_pkg::node_id_t node_id = 3'd5
) (
    input  logic clk,
    input  logic rstn,
    input  logic sda_in,
    input  logic rd_wrt,
    input  logic bus_util,
    input  logic arbiter_cmd,
    input  logic freeze_sw,
    output logic sda_oe,
    output logic sda_out,
    output logic busy
);

    sbus_link_if link_if ();
    sbus_mem_if  mem_if ();

    bit_shifter bit_shifter_inst (
        .clk    (clk),
        .rstn   (rstn),
        .sda_in (sda_in),
        .link   (link_if.shifter)
    );

    slave_ctrl #(
        .node_id (node_id)
    ) slave_ctrl_inst (
        .clk         (clk),
        .rstn        (rstn),
        .sda_in      (sda_in),
        .rd_wrt      (rd_wrt),
        .bus_util    (bus_util),
        .arbiter_cmd (arbiter_cmd),
        .freeze_sw   (freeze_sw),
        .sda_oe      (sda_oe),
        .sda_out     (sda_out),
        .busy        (busy),
        .link        (link_if.ctrl),
        .mem         (mem_if.ctrl)
    );

    local_mem local_mem_inst (
        .clk  (clk),
        .rstn (rstn),
        .mem  (mem_if.mem)
    );

endmodule

`default_nettype wire

//--- test/sbus_node_sva.sv
/* Concurrent checks on the node controller and its memory handshake.
   Attached to every slave_ctrl instance by the bind at the bottom. */
`timescale 1ns/1ps
`default_nettype none

module sbus_node_sva (
    input logic                   clk,
    input logic                   rstn,
    input sbus_pkg::slave_state_t state,
    input logic                   sda_oe,
    input logic                   busy,
    input logic                   req,
    input logic                   done
);

    // fixed memory latency, both ways round
    assert property (@(posedge clk) disable iff (!rstn)
        req |-> ##(sbus_pkg::MEM_LATENCY) done)
        else $error("memory done missing after a request");

    assert property (@(posedge clk) disable iff (!rstn)
        done |-> $past(req, sbus_pkg::MEM_LATENCY))
        else $error("memory done without a matching request");

    // line released while another node owns the frame or while frozen
    assert property (@(posedge clk) disable iff (!rstn)
        (state == sbus_pkg::WAIT_PEER || state == sbus_pkg::FREEZE) |-> !sda_oe)
        else $error("node drives the line in WAIT_PEER or FREEZE");

    assert property (@(posedge clk) disable iff (!rstn)
        (state == sbus_pkg::IDLE) |-> !busy)
        else $error("busy high while idle");

endmodule

bind slave_ctrl sbus_node_sva sva_inst (
    .clk    (clk),
    .rstn   (rstn),
    .state  (state),
    .sda_oe (sda_oe),
    .busy   (busy),
    .req    (wr_en_q | rd_req_q),
    .done   (mem.done)
);

`default_nettype wire

//--- test/tb_sbus_node.sv
/* Testbench for the serial bus node. Plays master and arbiter, applies a table of
   write and read frames and checks acks and read data against a memory model. */
`timescale 1ns/1ps
`default_nettype none

module tb_sbus_node;

    typedef struct packed {
        sbus_pkg::node_id_t id;
        logic               rd_wrt;
        sbus_pkg::addr_t    addr;
        sbus_pkg::data_t    data;
        logic [7:0]         freeze_cycles;
        logic               expect_response;
    } entry_t;

    localparam int NUM_ENTRIES = 16;
    localparam int TIMEOUT     = 100;

    logic            clk;
    logic            rstn;
    logic            line_drv;
    logic            sda_in;
    logic            rd_wrt;
    logic            bus_util;
    logic            arbiter_cmd;
    logic            freeze_sw;
    logic            sda_oe;
    logic            sda_out;
    logic            busy;
    logic [31:0]     lfsr;
    int              errors;
    int              timeouts;
    entry_t          tbl [NUM_ENTRIES];
    sbus_pkg::data_t mem_model [sbus_pkg::addr_t];

    // the node wins the line whenever it drives
    assign sda_in = sda_oe ? sda_out : line_drv;

    sbus_node #(
        .node_id (3'd5)
    ) sbus_node_inst (
        .clk         (clk),
        .rstn        (rstn),
        .sda_in      (sda_in),
        .rd_wrt      (rd_wrt),
        .bus_util    (bus_util),
        .arbiter_cmd (arbiter_cmd),
        .freeze_sw   (freeze_sw),
        .sda_oe      (sda_oe),
        .sda_out     (sda_out),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] v);
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // sel 0 polls sda_oe, sel 1 polls busy
    task automatic wait_level(input bit sel, input logic lvl, input string what);
        int n = 0;
        @(negedge clk);
        while (((sel ? busy : sda_oe) !== lvl) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if ((sel ? busy : sda_oe) !== lvl) begin
            timeouts++;
            $display("timed out at %0d ns waiting for %s", $time, what);
        end
    endtask

    task automatic send_bits(input logic [31:0] val, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            @(negedge clk);
            line_drv = val[i];
        end
    endtask

    // two driven cycles with sda_oe already seen high in the first
    task automatic expect_pair(input logic lvl0, input logic lvl1, input string what);
        check_value(32'(sda_out), 32'(lvl0), {what, " first cycle"});
        @(negedge clk);
        check_value(32'({sda_oe, sda_out}), 32'({1'b1, lvl1}), {what, " second cycle"});
        @(negedge clk);
        check_value(32'(sda_oe), 32'd0, {what, " release"});
    endtask

    task automatic run_entry(input entry_t e);
        sbus_pkg::data_t got;
        got       = '0;
        rd_wrt    = e.rd_wrt;
        freeze_sw = (e.freeze_cycles != 0);
        send_bits(32'({2'b00, e.id, e.addr}), 5 + sbus_pkg::ADDR_WIDTH);
        @(negedge clk);
        line_drv = 1'b1;
        if (!e.expect_response) begin
            repeat (12) begin
                @(negedge clk);
                check_value(32'({sda_oe, busy}), 32'd0, "quiet for a foreign id");
            end
            bus_util = 1'b1;
            @(negedge clk);
            bus_util = 1'b0;
        end else begin
            wait_level(1'b0, 1'b1, "address ack");
            expect_pair(1'b0, 1'b0, "address ack");
            if (e.rd_wrt) begin
                // low, then the marker bit, then the data
                line_drv = 1'b0;
                @(negedge clk);
                line_drv = 1'b1;
                send_bits(32'(e.data), sbus_pkg::DATA_WIDTH);
                @(negedge clk);
                line_drv = 1'b1;
            end
            wait_level(1'b1, 1'b1, "busy");
            repeat (e.freeze_cycles) begin
                check_value(32'({busy, sda_oe}), 32'b10, "freeze hold");
                @(negedge clk);
            end
            freeze_sw = 1'b0;
            wait_level(1'b1, 1'b0, "end of busy");
            arbiter_cmd = 1'b1;
            wait_level(1'b0, 1'b1, e.rd_wrt ? "write ack" : "read data");
            arbiter_cmd = 1'b0;
            if (e.rd_wrt) begin
                expect_pair(1'b0, 1'b1, "write ack");
                mem_model[e.addr] = e.data;
            end else begin
                check_value(32'(sda_out), 32'd0, "read start bit");
                repeat (sbus_pkg::DATA_WIDTH) begin
                    @(negedge clk);
                    check_value(32'(sda_oe), 32'd1, "read data driven");
                    got = {got[sbus_pkg::DATA_WIDTH-2:0], sda_out};
                end
                @(negedge clk);
                check_value(32'(sda_oe), 32'd0, "read release");
                check_value(32'(got), 32'(mem_model[e.addr]), "read data");
            end
        end
        repeat (3) @(negedge clk);
    endtask

    initial begin
        sbus_pkg::addr_t a;
        sbus_pkg::data_t d;
        rstn        = 1'b0;
        line_drv    = 1'b1;
        rd_wrt      = 1'b0;
        bus_util    = 1'b0;
        arbiter_cmd = 1'b0;
        freeze_sw   = 1'b0;
        errors      = 0;
        timeouts    = 0;
        lfsr        = 32'h283f_e456;

        // id, rd_wrt, addr, data, freeze_cycles, expect_response
        tbl[0] = '{3'd5, 1'b1, 8'h3c, 8'ha5, 8'd0, 1'b1};
        tbl[1] = '{3'd5, 1'b0, 8'h3c, 8'h00, 8'd0, 1'b1};
        tbl[2] = '{3'd2, 1'b1, 8'h3c, 8'h00, 8'd0, 1'b0};
        tbl[3] = '{3'd5, 1'b1, 8'h81, 8'h5a, 8'd6, 1'b1};
        tbl[4] = '{3'd5, 1'b0, 8'h81, 8'h00, 8'd4, 1'b1};
        tbl[5] = '{3'd5, 1'b0, 8'h3c, 8'h00, 8'd0, 1'b1};
        for (int k = 0; k < 4; k++) begin
            random_byte(a);
            random_byte(d);
            tbl[6 + 2*k] = '{3'd5, 1'b1, a, d, 8'(k), 1'b1};
            tbl[7 + 2*k] = '{3'd5, 1'b0, a, 8'h00, 8'd0, 1'b1};
        end
        // overwrite of the first random address
        random_byte(d);
        tbl[14] = '{3'd5, 1'b1, tbl[6].addr, d, 8'd2, 1'b1};
        tbl[15] = '{3'd5, 1'b0, tbl[6].addr, 8'h00, 8'd0, 1'b1};

        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value(32'({sda_oe, busy}), 32'd0, "idle after reset");

        for (int i = 0; i < NUM_ENTRIES && timeouts == 0; i++) begin
            run_entry(tbl[i]);
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/sbus_pkg.sv
rtl/sbus_link_if.sv
rtl/sbus_mem_if.sv
rtl/bit_shifter.sv
rtl/slave_ctrl.sv
rtl/local_mem.sv
rtl/sbus_node.sv
test/sbus_node_sva.sv
test/tb_sbus_node.sv

//--- run.sh
#!/bin/sh
# build the serial bus node testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sbus_node \
    -f project.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation run did not finish cleanly"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log 2>/dev/null && echo "simulation ok" && exit 0 \
    || { echo "simulation failed"; exit 1; }
